/* design/mem_pkg.sv */
// Shared definitions for the game SDRAM sharing logic
// Region map, slot numbering and widths, and the request, command
// and response records passed between the slot, arbiter and return blocks
`default_nettype none

package mem_pkg;

    // SDRAM word address width
    localparam int sdram_aw = 22;

    // Region bases in the SDRAM, in 16-bit word units
    localparam logic [21:0] main_rom_offset = 22'h00_0000;
    localparam logic [21:0] sound_offset    = 22'h08_0000;
    localparam logic [21:0] gfx_offset      = 22'h0A_8000;
    localparam logic [21:0] ram_offset      = 22'h3A_8000;

    // Slot numbers, lower number wins arbitration
    localparam logic [1:0] slot_main_rom = 2'd0;
    localparam logic [1:0] slot_ram      = 2'd1;
    localparam logic [1:0] slot_gfx      = 2'd2;
    localparam logic [1:0] slot_sound    = 2'd3;
    localparam int         slot_count    = 4;

    // Client address widths
    localparam int main_rom_aw = 19;
    localparam int ram_aw      = 17;
    localparam int gfx_aw      = 20;
    localparam int sound_aw    = 16;

    // Client data widths
    localparam int main_rom_dw = 16;
    localparam int ram_dw      = 16;
    localparam int gfx_dw      = 32;
    localparam int sound_dw    = 8;

    // Address unit, as log2 of the unit size in bytes
    localparam int unit_byte = 0;
    localparam int unit_half = 1;
    localparam int unit_word = 2;

    // Arbiter FSM states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_ack  = 2'd1;
    localparam logic [1:0] st_data = 2'd2;

    // SDRAM read word, low half and byte 0 at the lower address
    typedef union packed {
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } sdram_word_t;

    typedef struct packed {
        logic                pending;
        logic                wr;
        logic [sdram_aw-1:0] addr;
        logic [1:0]          lane;
        logic [15:0]         din;
        logic [1:0]          wrmask;
    } slot_req_t;

    typedef struct packed {
        logic                req;
        logic                rnw;
        logic [sdram_aw-1:0] addr;
        logic [1:0]          wrmask;
        logic [15:0]         data;
    } sdram_cmd_t;

    typedef struct packed {
        logic        done;
        logic        valid;
        logic [31:0] data;
    } slot_resp_t;

endpackage

`default_nettype wire

/* design/slot_cache.sv */
// Slot front end with a one-entry cache
// Captures a missed request, forms its SDRAM address and keeps the
// returned word so that repeated reads of the same address hit at once
`default_nettype none

module slot_cache #(
    parameter logic [21:0] offset = 22'd0,
    parameter int          aw     = 16,
    parameter int          unit   = mem_pkg::unit_half
) (
    input  logic                   VB,
    input  logic                   rst_n,
    input  logic                   cs,
    input  logic [aw-1:0]          addr,
    input  logic                   wr,
    input  logic [15:0]            din,
    input  logic [1:0]             wrmask,
    input  logic                   flush,
    input  mem_pkg::slot_resp_t    resp,
    output mem_pkg::slot_req_t     req,
    output logic                   ok,
    output logic [(8 << unit)-1:0] dout
);

    logic [aw-1:0]          last_addr;
    logic                   last_wr;
    logic [15:0]            last_din;
    logic [1:0]             last_mask;
    logic [(8 << unit)-1:0] data;
    logic                   valid;
    logic                   written;
    logic                   pending;
    logic                   same;
    logic                   rd_hit;
    logic                   wr_hit;
    logic                   miss;
    logic [21:0]            scaled;
    logic [1:0]             lane;

    assign same   = addr == last_addr;
    assign rd_hit = cs && same && valid && !wr;
    // A finished write keeps answering while the client holds it
    assign wr_hit = cs && same && written && wr && din == last_din && wrmask == last_mask;
    assign ok     = rd_hit || wr_hit;
    assign miss   = cs && !ok && !pending;
    assign dout   = data;

    // Scale the client address into 16-bit SDRAM words
    always_comb begin
        if (unit == mem_pkg::unit_byte) begin
            scaled = 22'(last_addr >> 1);
            lane   = {1'b0, last_addr[0]};
        end else if (unit == mem_pkg::unit_word) begin
            scaled = 22'({last_addr, 1'b0});
            lane   = 2'd0;
        end else begin
            scaled = 22'(last_addr);
            lane   = 2'd0;
        end
    end

    assign req = '{
        pending: pending,
        wr:      last_wr,
        addr:    offset + scaled,
        lane:    lane,
        din:     last_din,
        wrmask:  last_mask
    };

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            valid   <= 1'b0;
            written <= 1'b0;
        end else begin
            if (miss) begin
                pending <= 1'b1;
                valid   <= 1'b0;
                written <= 1'b0;
            end else if (resp.done) begin
                pending <= 1'b0;
                valid   <= resp.valid && !last_wr;
                written <= last_wr;
            end else if (written && !wr_hit) begin
                written <= 1'b0;
            end
            // ROM download in progress, forget everything
            if (flush) begin
                valid   <= 1'b0;
                written <= 1'b0;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (miss) begin
            last_addr <= addr;
            last_wr   <= wr;
            last_din  <= din;
            last_mask <= wrmask;
        end
        if (resp.valid && !last_wr) begin
            data <= resp.data[(8 << unit)-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/slot_arbiter.sv */
// Fixed-priority SDRAM arbiter
// Picks the lowest pending slot, holds its command through the
// req/ack handshake and waits for the data return before the next grant
`default_nettype none

module slot_arbiter (
    input  logic                                         VB,
    input  logic                                         rst_n,
    input  mem_pkg::slot_req_t [mem_pkg::slot_count-1:0] reqs,
    input  logic                                         downloading,
    input  logic                                         ack,
    input  logic                                         done,
    output mem_pkg::sdram_cmd_t                          cmd,
    output logic [1:0]                                   grant,
    output logic                                         refresh_en
);

    logic [1:0]  state;
    logic        any_pending;
    logic [1:0]  pick;
    logic        launch;
    logic        req_q;
    logic        rnw_q;
    logic [21:0] addr_q;
    logic [1:0]  mask_q;
    logic [15:0] data_q;

    // Lowest slot number wins
    always_comb begin
        any_pending = 1'b0;
        pick        = 2'd0;
        for (int i = mem_pkg::slot_count - 1; i >= 0; i--) begin
            if (reqs[i].pending) begin
                any_pending = 1'b1;
                pick        = 2'(i);
            end
        end
    end

    // No new access while the ROM loader owns the SDRAM
    assign launch     = state == mem_pkg::st_idle && any_pending && !downloading;
    assign refresh_en = state == mem_pkg::st_idle && !any_pending;

    assign cmd = '{
        req:    req_q,
        rnw:    rnw_q,
        addr:   addr_q,
        wrmask: mask_q,
        data:   data_q
    };

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::st_idle;
            req_q <= 1'b0;
            grant <= 2'd0;
        end else begin
            case (state)
                mem_pkg::st_idle: begin
                    if (launch) begin
                        grant <= pick;
                        req_q <= 1'b1;
                        state <= mem_pkg::st_ack;
                    end
                end
                mem_pkg::st_ack: begin
                    if (ack) begin
                        req_q <= 1'b0;
                        state <= mem_pkg::st_data;
                    end
                end
                mem_pkg::st_data: begin
                    // Read data or write completion came back
                    if (done) begin
                        state <= mem_pkg::st_idle;
                    end
                end
                default: begin
                    state <= mem_pkg::st_idle;
                end
            endcase
        end
    end

    // Command snapshot, the slot may move on once it gets ok
    always_ff @(posedge VB) begin
        if (launch) begin
            rnw_q  <= !reqs[pick].wr;
            addr_q <= reqs[pick].addr;
            mask_q <= reqs[pick].wrmask;
            data_q <= reqs[pick].din;
        end
    end

endmodule

`default_nettype wire

/* design/sdram_return.sv */
// SDRAM read return path
// Aligns the read word to the granted slot's width and lane and
// hands it, registered, to that slot together with a done pulse
`default_nettype none

module sdram_return (
    input  logic                                          VB,
    input  logic                                          rst_n,
    input  logic                                          data_rdy,
    input  mem_pkg::sdram_word_t                          data_read,
    input  logic [1:0]                                    grant,
    input  logic [1:0]                                    lane,
    output mem_pkg::slot_resp_t [mem_pkg::slot_count-1:0] resps,
    output logic                                          done
);

    logic [31:0] aligned;
    logic [31:0] data_q;
    logic [1:0]  slot_q;
    logic        done_q;

    // Graphics takes the whole word, sound one byte, the CPUs the low half
    always_comb begin
        case (grant)
            mem_pkg::slot_gfx:   aligned = data_read;
            mem_pkg::slot_sound: aligned = {24'd0, data_read.bytes[lane]};
            default:             aligned = {16'd0, data_read.half[0]};
        endcase
    end

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            slot_q <= 2'd0;
        end else begin
            done_q <= data_rdy;
            if (data_rdy) begin
                slot_q <= grant;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (data_rdy) begin
            data_q <= aligned;
        end
    end

    assign done = done_q;

    // Only the owner of the access sees the pulse
    always_comb begin
        for (int i = 0; i < mem_pkg::slot_count; i++) begin
            resps[i].done  = done_q && slot_q == 2'(i);
            resps[i].valid = done_q && slot_q == 2'(i);
            resps[i].data  = data_q;
        end
    end

endmodule

`default_nettype wire

/* design/game_sdram_mux.sv */
// Game SDRAM sharing top level
// Four client slots, each behind a one-entry cache, share one SDRAM
// controller through a fixed-priority arbiter and a lane-aligning return path
`default_nettype none

module game_sdram_mux (
    input  logic                            VB,
    input  logic                            rst_n,
    input  logic                            downloading,
    // Main CPU ROM
    input  logic                            main_rom_cs,
    input  logic [mem_pkg::main_rom_aw-1:0] main_rom_addr,
    output logic                            main_rom_ok,
    output logic [mem_pkg::main_rom_dw-1:0] main_rom_dout,
    // Main CPU work RAM
    input  logic                            ram_cs,
    input  logic [mem_pkg::ram_aw-1:0]      ram_addr,
    input  logic                            ram_wr,
    input  logic [15:0]                     ram_din,
    input  logic [1:0]                      ram_wrmask,
    output logic                            ram_ok,
    output logic [mem_pkg::ram_dw-1:0]      ram_dout,
    // Graphics ROM
    input  logic                            gfx_cs,
    input  logic [mem_pkg::gfx_aw-1:0]      gfx_addr,
    output logic                            gfx_ok,
    output logic [mem_pkg::gfx_dw-1:0]      gfx_dout,
    // Sound CPU ROM
    input  logic                            sound_cs,
    input  logic [mem_pkg::sound_aw-1:0]    sound_addr,
    output logic                            sound_ok,
    output logic [mem_pkg::sound_dw-1:0]    sound_dout,
    // SDRAM controller
    output logic                            sdram_req,
    input  logic                            sdram_ack,
    output logic [21:0]                     sdram_addr,
    output logic                            sdram_rnw,
    output logic [1:0]                      sdram_wrmask,
    output logic [15:0]                     data_write,
    input  logic                            data_rdy,
    input  logic [31:0]                     data_read,
    output logic                            refresh_en
);

    mem_pkg::slot_req_t  [mem_pkg::slot_count-1:0] slot_reqs;
    mem_pkg::slot_resp_t [mem_pkg::slot_count-1:0] slot_resps;
    mem_pkg::sdram_cmd_t                           cmd;
    logic [1:0]                                    grant;
    logic                                          ret_done;

    assign sdram_req    = cmd.req;
    assign sdram_rnw    = cmd.rnw;
    assign sdram_addr   = cmd.addr;
    assign sdram_wrmask = cmd.wrmask;
    assign data_write   = cmd.data;

    slot_cache #(
        .offset (mem_pkg::main_rom_offset),
        .aw     (mem_pkg::main_rom_aw),
        .unit   (mem_pkg::unit_half)
    ) u_main_rom (
        .VB     (VB),
        .rst_n  (rst_n),
        .cs     (main_rom_cs),
        .addr   (main_rom_addr),
        .wr     (1'b0),
        .din    (16'd0),
        .wrmask (2'b11),
        .flush  (downloading),
        .resp   (slot_resps[mem_pkg::slot_main_rom]),
        .req    (slot_reqs[mem_pkg::slot_main_rom]),
        .ok     (main_rom_ok),
        .dout   (main_rom_dout)
    );

    // Work RAM is the only slot that writes
    slot_cache #(
        .offset (mem_pkg::ram_offset),
        .aw     (mem_pkg::ram_aw),
        .unit   (mem_pkg::unit_half)
    ) u_ram (
        .VB     (VB),
        .rst_n  (rst_n),
        .cs     (ram_cs),
        .addr   (ram_addr),
        .wr     (ram_wr),
        .din    (ram_din),
        .wrmask (ram_wrmask),
        .flush  (downloading),
        .resp   (slot_resps[mem_pkg::slot_ram]),
        .req    (slot_reqs[mem_pkg::slot_ram]),
        .ok     (ram_ok),
        .dout   (ram_dout)
    );

    slot_cache #(
        .offset (mem_pkg::gfx_offset),
        .aw     (mem_pkg::gfx_aw),
        .unit   (mem_pkg::unit_word)
    ) u_gfx (
        .VB     (VB),
        .rst_n  (rst_n),
        .cs     (gfx_cs),
        .addr   (gfx_addr),
        .wr     (1'b0),
        .din    (16'd0),
        .wrmask (2'b11),
        .flush  (downloading),
        .resp   (slot_resps[mem_pkg::slot_gfx]),
        .req    (slot_reqs[mem_pkg::slot_gfx]),
        .ok     (gfx_ok),
        .dout   (gfx_dout)
    );

    slot_cache #(
        .offset (mem_pkg::sound_offset),
        .aw     (mem_pkg::sound_aw),
        .unit   (mem_pkg::unit_byte)
    ) u_sound (
        .VB     (VB),
        .rst_n  (rst_n),
        .cs     (sound_cs),
        .addr   (sound_addr),
        .wr     (1'b0),
        .din    (16'd0),
        .wrmask (2'b11),
        .flush  (downloading),
        .resp   (slot_resps[mem_pkg::slot_sound]),
        .req    (slot_reqs[mem_pkg::slot_sound]),
        .ok     (sound_ok),
        .dout   (sound_dout)
    );

    slot_arbiter u_arbiter (
        .VB          (VB),
        .rst_n       (rst_n),
        .reqs        (slot_reqs),
        .downloading (downloading),
        .ack         (sdram_ack),
        .done        (ret_done),
        .cmd         (cmd),
        .grant       (grant),
        .refresh_en  (refresh_en)
    );

    // Granted slot holds its request until done, so its lane is stable
    sdram_return u_return (
        .VB        (VB),
        .rst_n     (rst_n),
        .data_rdy  (data_rdy),
        .data_read (data_read),
        .grant     (grant),
        .lane      (slot_reqs[grant].lane),
        .resps     (slot_resps),
        .done      (ret_done)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Testbench clock and reset source
// Free-running clock with a period of 4 and an active-low reset
// released on a falling edge after 10 cycles
`default_nettype none

module tb_clock (
    output logic VB,
    output logic rst_n
);

    initial begin
        VB = 1'b0;
        forever #2 VB = ~VB;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge VB);
        @(negedge VB);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/sdram_model.sv */
// Behavioral SDRAM controller
// Answers req with an ack after a random delay and returns data_rdy
// later; unwritten words come from an address-mixing pattern
`default_nettype none

module sdram_model (
    input  logic        VB,
    input  logic        rst_n,
    input  logic        req,
    input  logic [21:0] addr,
    input  logic        rnw,
    input  logic [1:0]  wrmask,
    input  logic [15:0] wdata,
    output logic        ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    logic [15:0] mem [logic [21:0]];

    // Content of a word nobody has written yet
    function automatic logic [15:0] pattern_word(input logic [21:0] a);
        logic [21:0] mixed;
        mixed = a ^ (a >> 11);
        return 16'(mixed) * 16'h9e37 + 16'h5a3c;
    endfunction

    function automatic logic [15:0] read_word(input logic [21:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return pattern_word(a);
    endfunction

    // Active-low mask, one bit per byte
    task automatic write_word(input logic [21:0] a, input logic [1:0] m, input logic [15:0] d);
        logic [15:0] cur;
        cur = read_word(a);
        if (!m[0]) begin
            cur[7:0] = d[7:0];
        end
        if (!m[1]) begin
            cur[15:8] = d[15:8];
        end
        mem[a] = cur;
    endtask

    initial begin
        logic [21:0] a;
        logic        rd;
        logic [1:0]  m;
        logic [15:0] d;
        int          delay;
        ack       = 1'b0;
        data_rdy  = 1'b0;
        data_read = 32'd0;
        forever begin
            @(negedge VB);
            if (rst_n && req) begin
                delay = 1 + int'($urandom % 4);
                repeat (delay - 1) @(negedge VB);
                a   = addr;
                rd  = rnw;
                m   = wrmask;
                d   = wdata;
                ack = 1'b1;
                @(negedge VB);
                ack   = 1'b0;
                delay = 2 + int'($urandom % 5);
                repeat (delay - 1) @(negedge VB);
                if (rd) begin
                    data_read = {read_word(a + 22'd1), read_word(a)};
                end else begin
                    write_word(a, m, d);
                end
                data_rdy = 1'b1;
                @(negedge VB);
                data_rdy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_game_sdram_mux.sv */
// Testbench for the game SDRAM sharing logic
// Random clients on all four slots, a reference memory model, protocol
// checks on the SDRAM side and periodic ROM download phases
`default_nettype none

module tb_game_sdram_mux;

    localparam int n_trans   = 800;
    localparam int dl_period = 200;
    localparam int dl_len    = 20;
    localparam int timeout   = n_trans * 64 * 4 + (n_trans / dl_period + 1) * dl_len * 8 + 2000;

    logic        VB;
    logic        rst_n;
    logic        downloading;
    logic [3:0]  cs;
    logic [19:0] addr [4];
    logic        ram_wr;
    logic [15:0] ram_din;
    logic [1:0]  ram_wrmask;
    logic        sdram_ack;
    logic        data_rdy;
    logic [31:0] data_read;
    logic        main_rom_ok;
    logic        ram_ok;
    logic        gfx_ok;
    logic        sound_ok;
    logic [15:0] main_rom_dout;
    logic [15:0] ram_dout;
    logic [31:0] gfx_dout;
    logic [7:0]  sound_dout;
    logic        sdram_req;
    logic        sdram_rnw;
    logic        refresh_en;
    logic [21:0] sdram_addr;
    logic [1:0]  sdram_wrmask;
    logic [15:0] data_write;
    logic [3:0]  ok;
    logic [31:0] dout [4];

    // Client and reference state
    logic [19:0] pool [4][8];
    logic [19:0] last_addr [4];
    logic [3:0]  known;
    logic [3:0]  flushed;
    logic [3:0]  fresh;
    logic [3:0]  expect_hit;
    logic [3:0]  expect_miss;
    logic [3:0]  seen_ok;
    logic [3:0]  stuck;
    logic [15:0] mirror [logic [21:0]];
    logic        draining;
    int          done_count;
    int          next_dl;
    logic        prev_req;
    logic        prev_ack;
    logic        prev_dl;
    logic [21:0] cmd_addr;
    logic        cmd_rnw;
    logic [1:0]  cmd_mask;
    logic [15:0] cmd_data;

    assign ok      = {sound_ok, gfx_ok, ram_ok, main_rom_ok};
    assign dout[0] = {16'd0, main_rom_dout};
    assign dout[1] = {16'd0, ram_dout};
    assign dout[2] = gfx_dout;
    assign dout[3] = {24'd0, sound_dout};

    tb_clock u_clock (.VB(VB), .rst_n(rst_n));

    game_sdram_mux DUT (
        .VB(VB), .rst_n(rst_n), .downloading(downloading),
        .main_rom_cs(cs[0]), .main_rom_addr(addr[0][18:0]),
        .main_rom_ok(main_rom_ok), .main_rom_dout(main_rom_dout),
        .ram_cs(cs[1]), .ram_addr(addr[1][16:0]), .ram_wr(ram_wr), .ram_din(ram_din),
        .ram_wrmask(ram_wrmask), .ram_ok(ram_ok), .ram_dout(ram_dout),
        .gfx_cs(cs[2]), .gfx_addr(addr[2]), .gfx_ok(gfx_ok), .gfx_dout(gfx_dout),
        .sound_cs(cs[3]), .sound_addr(addr[3][15:0]), .sound_ok(sound_ok),
        .sound_dout(sound_dout),
        .sdram_req(sdram_req), .sdram_ack(sdram_ack), .sdram_addr(sdram_addr),
        .sdram_rnw(sdram_rnw), .sdram_wrmask(sdram_wrmask), .data_write(data_write),
        .data_rdy(data_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    sdram_model u_sdram (
        .VB(VB), .rst_n(rst_n), .req(sdram_req), .addr(sdram_addr), .rnw(sdram_rnw),
        .wrmask(sdram_wrmask), .wdata(data_write), .ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    function automatic logic [15:0] content_word(input logic [21:0] a);
        logic [21:0] mixed;
        mixed = a ^ (a >> 11);
        return 16'(mixed) * 16'h9e37 + 16'h5a3c;
    endfunction

    function automatic logic [15:0] stored_word(input logic [21:0] a);
        if (mirror.exists(a)) begin
            return mirror[a];
        end
        return content_word(a);
    endfunction

    function automatic logic [21:0] slot_sdram_addr(input int s, input logic [19:0] a);
        case (s)
            0:       return mem_pkg::main_rom_offset + 22'(a[18:0]);
            1:       return mem_pkg::ram_offset + 22'(a[16:0]);
            2:       return mem_pkg::gfx_offset + 22'({a, 1'b0});
            default: return mem_pkg::sound_offset + 22'(a[15:1]);
        endcase
    endfunction

    function automatic logic [31:0] expected_dout(input int s, input logic [19:0] a);
        logic [21:0] base;
        logic [15:0] w;
        base = slot_sdram_addr(s, a);
        w    = stored_word(base);
        if (s == 2) begin
            return {stored_word(base + 22'd1), w};
        end else if (s == 3) begin
            return {24'd0, a[0] ? w[15:8] : w[7:0]};
        end
        return {16'd0, w};
    endfunction

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic start_request(input int s);
        int idx;
        idx     = int'($urandom % 8);
        addr[s] = pool[s][idx];
        if (s == 1) begin
            ram_wr     = ($urandom % 3) == 0;
            ram_din    = 16'($urandom);
            ram_wrmask = 2'($urandom);
        end
        expect_hit[s]  = known[s] && addr[s] == last_addr[s] && !(s == 1 && ram_wr);
        expect_miss[s] = flushed[s] && addr[s] == last_addr[s];
        fresh[s]       = 1'b1;
        seen_ok[s]     = 1'b0;
        cs[s]          = 1'b1;
    endtask

    // Sampled on the rising edge after the falling-edge drive has settled
    always @(posedge VB) begin
        logic        found;
        logic [15:0] w;
        logic [21:0] a;
        if (rst_n) begin
            for (int s = 0; s < 4; s++) begin
                if (cs[s] && fresh[s]) begin
                    if (expect_hit[s]) begin
                        assert (ok[s]) else report_failure("cached read missed");
                    end
                    if (expect_miss[s]) begin
                        assert (!ok[s]) else report_failure("hit after download");
                    end
                    fresh[s] = 1'b0;
                end
                if (cs[s] && ok[s]) begin
                    seen_ok[s] = 1'b1;
                    if (!(s == 1 && ram_wr)) begin
                        assert (dout[s] == expected_dout(s, addr[s]))
                        else report_failure($sformatf("slot %0d read data mismatch", s));
                    end
                end
                if (cs[s] && !ok[s] && stuck[s]) begin
                    assert (!refresh_en) else report_failure("refresh_en high with pending slot");
                end
                stuck[s] = cs[s] && !ok[s];
            end
            // Completed RAM write goes into the reference memory
            if (cs[1] && ok[1] && ram_wr) begin
                a = slot_sdram_addr(1, addr[1]);
                w = stored_word(a);
                if (!ram_wrmask[0]) w[7:0] = ram_din[7:0];
                if (!ram_wrmask[1]) w[15:8] = ram_din[15:8];
                mirror[a] = w;
            end
            if (cs == 4'd0) begin
                assert (refresh_en) else report_failure("refresh_en low while idle");
            end
            if (sdram_req && !prev_req) begin
                assert (!prev_dl) else report_failure("sdram_req rose during download");
                found = 1'b0;
                for (int s = 0; s < 4; s++) begin
                    if (cs[s] && slot_sdram_addr(s, addr[s]) == sdram_addr &&
                        sdram_rnw == !(s == 1 && ram_wr) &&
                        (sdram_rnw || (sdram_wrmask == ram_wrmask && data_write == ram_din))) begin
                        found = 1'b1;
                    end
                end
                assert (found) else report_failure("SDRAM command matches no pending slot");
                cmd_addr = sdram_addr;
                cmd_rnw  = sdram_rnw;
                cmd_mask = sdram_wrmask;
                cmd_data = data_write;
            end
            if (sdram_req && prev_req) begin
                assert (sdram_addr == cmd_addr && sdram_rnw == cmd_rnw &&
                        (cmd_rnw || (sdram_wrmask == cmd_mask && data_write == cmd_data)))
                else report_failure("SDRAM command changed before ack");
            end
            if (prev_req && !sdram_req) begin
                assert (prev_ack) else report_failure("sdram_req dropped without ack");
            end
            prev_req = sdram_req;
            prev_ack = sdram_ack;
            prev_dl  = downloading;
        end
    end

    initial begin
        #(timeout);
        $display("Watchdog expired before all transactions completed");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'he1e3d0c9));
        downloading = 1'b0;
        cs          = 4'd0;
        ram_wr      = 1'b0;
        ram_din     = 16'd0;
        ram_wrmask  = 2'b11;
        known       = 4'd0;
        flushed     = 4'd0;
        fresh       = 4'd0;
        expect_hit  = 4'd0;
        expect_miss = 4'd0;
        seen_ok     = 4'd0;
        stuck       = 4'd0;
        draining    = 1'b0;
        done_count  = 0;
        next_dl     = dl_period;
        prev_req    = 1'b0;
        prev_ack    = 1'b0;
        prev_dl     = 1'b0;
        for (int s = 0; s < 4; s++) begin
            addr[s]      = 20'd0;
            last_addr[s] = 20'd0;
            for (int i = 0; i < 8; i++) begin
                pool[s][i] = 20'($urandom);
            end
        end
        wait (rst_n);
        while (done_count < n_trans) begin
            @(negedge VB);
            for (int s = 0; s < 4; s++) begin
                if (cs[s]) begin
                    if (seen_ok[s]) begin
                        done_count++;
                        last_addr[s] = addr[s];
                        known[s]     = !(s == 1 && ram_wr);
                        flushed[s]   = 1'b0;
                        if (!draining && ($urandom % 2) == 0) begin
                            start_request(s);
                        end else begin
                            cs[s] = 1'b0;
                        end
                    end
                end else if (!draining && ($urandom % 4) == 0) begin
                    start_request(s);
                end
            end
            // ROM download once all clients are quiet
            if (!draining && done_count >= next_dl) begin
                draining = 1'b1;
            end
            if (draining && cs == 4'd0) begin
                downloading = 1'b1;
                flushed     = known;
                known       = 4'd0;
                // Clients that ask during the download are held off until it ends
                repeat (dl_len) begin
                    @(negedge VB);
                    for (int s = 0; s < 4; s++) begin
                        if (!cs[s] && ($urandom % 4) == 0) begin
                            start_request(s);
                        end
                    end
                end
                downloading = 1'b0;
                draining    = 1'b0;
                next_dl     = next_dl + dl_period;
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/mem_pkg.sv
design/slot_cache.sv
design/slot_arbiter.sv
design/sdram_return.sv
design/game_sdram_mux.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/tb_game_sdram_mux.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the game SDRAM mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_game_sdram_mux \
    --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
